//--- common/csr_pkg.sv
// Shared types and constants of the machine-mode CSR and trap unit.
// Only machine mode exists, so mstatus.mpp is a constant.
// Interrupt codes double as the mip/mie bit positions.

package csr_pkg;

    localparam int XLEN       = 32;  // data width
    localparam int CSR_ADDR_W = 12;  // csr address field
    localparam int CAUSE_W    = 5;   // low bits of mcause

    // instruction class seen by the unit
    typedef enum logic [3:0] {
        OP_NONE,
        OP_CSRRW,
        OP_CSRRS,
        OP_CSRRC,
        OP_ECALL,
        OP_EBREAK,
        OP_MRET,
        OP_LOAD,
        OP_STORE,
        OP_ILLEGAL
    } csr_op_e;

    // load/store access size
    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } ls_size_e;

    // machine csr addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE       = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC     = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL     = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP       = 12'h344;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH   = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRETH = 12'hB82;

    // synchronous exception codes
    localparam logic [CAUSE_W-1:0] EXC_ILLEGAL   = 5'd2;
    localparam logic [CAUSE_W-1:0] EXC_EBREAK    = 5'd3;
    localparam logic [CAUSE_W-1:0] EXC_LADDR_MIS = 5'd4;
    localparam logic [CAUSE_W-1:0] EXC_SADDR_MIS = 5'd6;
    localparam logic [CAUSE_W-1:0] EXC_ECALL_M   = 5'd11;

    // interrupt codes, also mip/mie bit index
    localparam logic [CAUSE_W-1:0] INT_MSI = 5'd3;
    localparam logic [CAUSE_W-1:0] INT_MTI = 5'd7;
    localparam logic [CAUSE_W-1:0] INT_MEI = 5'd11;

    // mstatus fields
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam logic [1:0] MSTATUS_MPP_VAL = 2'b11;  // machine mode only

endpackage

//--- trap/exc_detect.sv
// Synchronous exception detection for the instruction on the current strobe.
// Priority: illegal, ecall, ebreak, misaligned load/store.
// Byte accesses never misalign; the trap value is nonzero only for misalignment.

module exc_detect (
    input  logic                         s_valid_i,
    input  csr_pkg::csr_op_e             s_op_i,
    input  csr_pkg::ls_size_e            s_size_i,
    input  logic [csr_pkg::XLEN-1:0]     s_val_i,         // ls address
    input  logic                         s_addr_legal_i,
    output logic                         s_exc_o,
    output logic [csr_pkg::CAUSE_W-1:0]  s_exc_code_o,
    output logic [csr_pkg::XLEN-1:0]     s_exc_tval_o
);
    import csr_pkg::*;

    logic s_csr_op, s_ls_op, s_misaligned;
    logic s_illegal, s_ecall, s_ebreak, s_ls_mis, s_mis_wins;

    assign s_csr_op = (s_op_i == OP_CSRRW) | (s_op_i == OP_CSRRS) | (s_op_i == OP_CSRRC);
    assign s_ls_op  = (s_op_i == OP_LOAD) | (s_op_i == OP_STORE);

    always_comb begin
        case (s_size_i)
            SIZE_BYTE: s_misaligned = 1'b0;
            SIZE_HALF: s_misaligned = s_val_i[0];
            SIZE_WORD: s_misaligned = |s_val_i[1:0];
            default:   s_misaligned = 1'b0;  // unused encoding
        endcase
    end

    assign s_illegal  = (s_op_i == OP_ILLEGAL) | (s_csr_op & ~s_addr_legal_i);
    assign s_ecall    = s_op_i == OP_ECALL;
    assign s_ebreak   = s_op_i == OP_EBREAK;
    assign s_ls_mis   = s_ls_op & s_misaligned;
    assign s_mis_wins = s_ls_mis & ~(s_illegal | s_ecall | s_ebreak);

    assign s_exc_o = s_valid_i & (s_illegal | s_ecall | s_ebreak | s_ls_mis);

    assign s_exc_code_o = s_illegal  ? EXC_ILLEGAL :
                          s_ecall    ? EXC_ECALL_M :
                          s_ebreak   ? EXC_EBREAK  :
                          (s_op_i == OP_STORE) ? EXC_SADDR_MIS : EXC_LADDR_MIS;

    assign s_exc_tval_o = s_mis_wins ? s_val_i : '0;  // faulting address

endmodule

//--- trap/trap_ctrl.sv
// Trap decision for the current strobe; the only place a trap is taken.
// Interrupts beat exceptions and are ordered MEI > MSI > MTI.
// Vectored mtvec offsets interrupts only, exceptions always go to the base.
// Without trap or mret the redirect is the next sequential pc.

module trap_ctrl (
    input  logic                         s_valid_i,
    input  csr_pkg::csr_op_e             s_op_i,
    input  logic [csr_pkg::XLEN-1:0]     s_pc_i,
    input  logic                         s_exc_i,
    input  logic [csr_pkg::CAUSE_W-1:0]  s_exc_code_i,
    input  logic                         s_mstatus_mie_i,  // global enable
    input  logic [csr_pkg::XLEN-1:0]     s_mie_i,
    input  logic [csr_pkg::XLEN-1:0]     s_mip_i,
    input  logic [csr_pkg::XLEN-1:0]     s_mtvec_i,
    input  logic [csr_pkg::XLEN-1:0]     s_mepc_i,
    output logic                         s_trap_o,
    output logic                         s_mret_o,
    output logic [csr_pkg::XLEN-1:0]     s_cause_o,
    output logic [csr_pkg::XLEN-1:0]     s_redirect_pc_o
);
    import csr_pkg::*;

    logic [XLEN-1:0]    s_enabled;
    logic               s_int_pending;
    logic [CAUSE_W-1:0] s_int_code;
    logic [XLEN-1:0]    s_base, s_vector, s_handler;

    assign s_enabled     = s_mie_i & s_mip_i;
    assign s_int_pending = s_mstatus_mie_i & (|s_enabled);

    // fixed priority among the enabled sources
    assign s_int_code = s_enabled[INT_MEI] ? INT_MEI :
                        s_enabled[INT_MSI] ? INT_MSI :
                        s_enabled[INT_MTI] ? INT_MTI : '0;

    assign s_trap_o = s_valid_i & (s_int_pending | s_exc_i);
    assign s_mret_o = s_valid_i & (s_op_i == OP_MRET) & ~s_trap_o;

    assign s_cause_o = {s_int_pending, {(XLEN-CAUSE_W-1){1'b0}},
                        s_int_pending ? s_int_code : s_exc_code_i};

    assign s_base    = {s_mtvec_i[XLEN-1:2], 2'b00};
    assign s_vector  = s_base + {{(XLEN-CAUSE_W-2){1'b0}}, s_int_code, 2'b00};  // base + 4*code
    assign s_handler = (s_mtvec_i[0] & s_int_pending) ? s_vector : s_base;

    assign s_redirect_pc_o = s_mret_o ? s_mepc_i  :
                             s_trap_o ? s_handler :
                             s_pc_i + 32'd4;

    // pending interrupt must map to one of the three sources
    always_comb begin
        assert (!s_int_pending || (s_int_code != '0))
            else $error("trap_ctrl: pending interrupt outside MEI/MSI/MTI");
    end

endmodule

//--- csr/csr_file.sv
// Machine CSR state with a one-cycle update at the rising clock edge.
// Writes land only when the strobe does not trap; mip is read-only.
// Trap entry and mret take precedence over a CSR write in the same cycle.
// mcycle runs from the first cycle after reset; minstret counts untrapped strobes.
// Unlisted addresses read zero and are flagged illegal.

module csr_file (
    input  logic                            s_clk_i,
    input  logic                            s_resetn_i,
    input  logic                            s_valid_i,
    input  csr_pkg::csr_op_e                s_op_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  s_csr_addr_i,
    input  logic [csr_pkg::XLEN-1:0]        s_val_i,
    input  logic [csr_pkg::XLEN-1:0]        s_pc_i,
    input  logic                            s_trap_i,
    input  logic                            s_mret_i,
    input  logic [csr_pkg::XLEN-1:0]        s_cause_i,
    input  logic [csr_pkg::XLEN-1:0]        s_exc_tval_i,
    input  logic                            s_int_meip_i,
    input  logic                            s_int_mtip_i,
    input  logic                            s_int_msip_i,
    output logic [csr_pkg::XLEN-1:0]        s_rdata_o,
    output logic                            s_addr_legal_o,
    output logic                            s_mstatus_mie_o,
    output logic [csr_pkg::XLEN-1:0]        s_mie_o,
    output logic [csr_pkg::XLEN-1:0]        s_mip_o,
    output logic [csr_pkg::XLEN-1:0]        s_mtvec_o,
    output logic [csr_pkg::XLEN-1:0]        s_mepc_o
);
    import csr_pkg::*;

    logic                s_mstatus_mie_q, s_mstatus_mpie_q;
    logic [XLEN-1:0]     s_mie_q, s_mip_q, s_mtvec_q, s_mscratch_q;
    logic [XLEN-1:0]     s_mepc_q, s_mcause_q, s_mtval_q;
    logic [2*XLEN-1:0]   s_mcycle_q, s_minstret_q;
    logic [XLEN-1:0]     s_mstatus, s_irq_mask, s_mip_nxt, s_wval;
    logic                s_csr_we, s_retire;

    // 64-bit counter step, a csr write replaces the addressed half
    function automatic logic [2*XLEN-1:0] cnt_next(input logic [2*XLEN-1:0] cnt,
                                                   input logic inc, input logic wr_lo,
                                                   input logic wr_hi, input logic [XLEN-1:0] wval);
        logic [2*XLEN-1:0] nxt;
        nxt = cnt + {{(2*XLEN-1){1'b0}}, inc};  // carry into high word
        if (wr_lo) begin
            nxt = {cnt[2*XLEN-1:XLEN], wval};
        end else if (wr_hi) begin
            nxt = {wval, cnt[XLEN-1:0]};
        end
        return nxt;
    endfunction

    always_comb begin
        s_irq_mask          = '0;
        s_irq_mask[INT_MSI] = 1'b1;
        s_irq_mask[INT_MTI] = 1'b1;
        s_irq_mask[INT_MEI] = 1'b1;
        s_mip_nxt           = '0;
        s_mip_nxt[INT_MSI]  = s_int_msip_i;
        s_mip_nxt[INT_MTI]  = s_int_mtip_i;
        s_mip_nxt[INT_MEI]  = s_int_meip_i;
        s_mstatus                = '0;
        s_mstatus[12:11]         = MSTATUS_MPP_VAL;
        s_mstatus[MSTATUS_MPIE]  = s_mstatus_mpie_q;
        s_mstatus[MSTATUS_MIE]   = s_mstatus_mie_q;
    end

    // read mux and legality share one decode
    always_comb begin
        s_addr_legal_o = 1'b1;
        case (s_csr_addr_i)
            CSR_MSTATUS:   s_rdata_o = s_mstatus;
            CSR_MIE:       s_rdata_o = s_mie_q;
            CSR_MTVEC:     s_rdata_o = s_mtvec_q;
            CSR_MSCRATCH:  s_rdata_o = s_mscratch_q;
            CSR_MEPC:      s_rdata_o = s_mepc_q;
            CSR_MCAUSE:    s_rdata_o = s_mcause_q;
            CSR_MTVAL:     s_rdata_o = s_mtval_q;
            CSR_MIP:       s_rdata_o = s_mip_q;
            CSR_MCYCLE:    s_rdata_o = s_mcycle_q[XLEN-1:0];
            CSR_MCYCLEH:   s_rdata_o = s_mcycle_q[2*XLEN-1:XLEN];
            CSR_MINSTRET:  s_rdata_o = s_minstret_q[XLEN-1:0];
            CSR_MINSTRETH: s_rdata_o = s_minstret_q[2*XLEN-1:XLEN];
            default: begin
                s_rdata_o      = '0;
                s_addr_legal_o = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (s_op_i)
            OP_CSRRW: s_wval = s_val_i;
            OP_CSRRS: s_wval = s_rdata_o | s_val_i;
            OP_CSRRC: s_wval = s_rdata_o & ~s_val_i;
            default:  s_wval = s_rdata_o;
        endcase
    end

    assign s_retire = s_valid_i & ~s_trap_i;
    assign s_csr_we = s_retire & ((s_op_i == OP_CSRRW) | (s_op_i == OP_CSRRS) |
                                  (s_op_i == OP_CSRRC));

    always_ff @(posedge s_clk_i) begin
        if (!s_resetn_i) begin
            s_mstatus_mie_q  <= 1'b0;
            s_mstatus_mpie_q <= 1'b0;
            s_mie_q          <= '0;
            s_mip_q          <= '0;
            s_mtvec_q        <= '0;
            s_mscratch_q     <= '0;
            s_mepc_q         <= '0;
            s_mcause_q       <= '0;
            s_mtval_q        <= '0;
        end else begin
            s_mip_q <= s_mip_nxt;  // mirrors input levels
            if (s_trap_i) begin
                s_mepc_q         <= s_pc_i;
                s_mcause_q       <= s_cause_i;
                s_mtval_q        <= s_cause_i[XLEN-1] ? '0 : s_exc_tval_i;
                s_mstatus_mpie_q <= s_mstatus_mie_q;
                s_mstatus_mie_q  <= 1'b0;
            end else if (s_mret_i) begin
                s_mstatus_mie_q  <= s_mstatus_mpie_q;
                s_mstatus_mpie_q <= 1'b1;
            end else if (s_csr_we) begin
                case (s_csr_addr_i)
                    CSR_MSTATUS: begin
                        s_mstatus_mie_q  <= s_wval[MSTATUS_MIE];
                        s_mstatus_mpie_q <= s_wval[MSTATUS_MPIE];
                    end
                    CSR_MIE:      s_mie_q      <= s_wval & s_irq_mask;
                    CSR_MTVEC:    s_mtvec_q    <= {s_wval[XLEN-1:2], 1'b0, s_wval[0]};
                    CSR_MSCRATCH: s_mscratch_q <= s_wval;
                    CSR_MEPC:     s_mepc_q     <= s_wval;
                    CSR_MCAUSE:   s_mcause_q   <= s_wval;
                    CSR_MTVAL:    s_mtval_q    <= s_wval;
                    default: ;                  // mip and counters handled elsewhere
                endcase
            end
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (!s_resetn_i) begin
            s_mcycle_q   <= '0;
            s_minstret_q <= '0;
        end else begin
            s_mcycle_q   <= cnt_next(s_mcycle_q, 1'b1,
                                     s_csr_we & (s_csr_addr_i == CSR_MCYCLE),
                                     s_csr_we & (s_csr_addr_i == CSR_MCYCLEH), s_wval);
            s_minstret_q <= cnt_next(s_minstret_q, s_retire,
                                     s_csr_we & (s_csr_addr_i == CSR_MINSTRET),
                                     s_csr_we & (s_csr_addr_i == CSR_MINSTRETH), s_wval);
        end
    end

    assign s_mstatus_mie_o = s_mstatus_mie_q;
    assign s_mie_o         = s_mie_q;
    assign s_mip_o         = s_mip_q;
    assign s_mtvec_o       = s_mtvec_q;
    assign s_mepc_o        = s_mepc_q;

    // warl fields hold across writes, traps and mret
    assert property (@(posedge s_clk_i) disable iff (!s_resetn_i) !s_mtvec_q[1])
        else $error("csr_file: mtvec bit 1 set");
    assert property (@(posedge s_clk_i) disable iff (!s_resetn_i)
                     (s_mie_q & ~s_irq_mask) == '0)
        else $error("csr_file: mie bit outside 3/7/11 set");

endmodule

//--- design/csr_unit_top.sv
// Machine-mode CSR and trap unit, one instruction per s_valid_i strobe.
// Outputs are combinational in the strobe cycle, state updates at the next edge.
// No back-pressure; an interrupt replaces the instruction it is taken on.

module csr_unit_top (
    input  logic                            s_clk_i,
    input  logic                            s_resetn_i,
    input  logic                            s_valid_i,       // one strobe per instruction
    input  csr_pkg::csr_op_e                s_op_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  s_csr_addr_i,
    input  logic [csr_pkg::XLEN-1:0]        s_val_i,         // operand or ls address
    input  csr_pkg::ls_size_e               s_size_i,
    input  logic [csr_pkg::XLEN-1:0]        s_pc_i,
    input  logic                            s_int_meip_i,    // level
    input  logic                            s_int_mtip_i,    // level
    input  logic                            s_int_msip_i,    // level
    output logic [csr_pkg::XLEN-1:0]        s_rdata_o,       // old csr value
    output logic                            s_trap_o,
    output logic                            s_mret_o,
    output logic [csr_pkg::XLEN-1:0]        s_redirect_pc_o
);
    import csr_pkg::*;

    logic               s_addr_legal;
    logic               s_mstatus_mie;
    logic [XLEN-1:0]    s_mie, s_mip, s_mtvec, s_mepc;
    logic               s_exc;
    logic [CAUSE_W-1:0] s_exc_code;
    logic [XLEN-1:0]    s_exc_tval;
    logic [XLEN-1:0]    s_cause;

    exc_detect exc_detect_inst (
        .s_valid_i(s_valid_i), .s_op_i(s_op_i), .s_size_i(s_size_i), .s_val_i(s_val_i),
        .s_addr_legal_i(s_addr_legal),
        .s_exc_o(s_exc), .s_exc_code_o(s_exc_code), .s_exc_tval_o(s_exc_tval)
    );

    trap_ctrl trap_ctrl_inst (
        .s_valid_i(s_valid_i), .s_op_i(s_op_i), .s_pc_i(s_pc_i),
        .s_exc_i(s_exc), .s_exc_code_i(s_exc_code),
        .s_mstatus_mie_i(s_mstatus_mie), .s_mie_i(s_mie), .s_mip_i(s_mip),
        .s_mtvec_i(s_mtvec), .s_mepc_i(s_mepc),
        .s_trap_o(s_trap_o), .s_mret_o(s_mret_o), .s_cause_o(s_cause),
        .s_redirect_pc_o(s_redirect_pc_o)
    );

    csr_file csr_file_inst (
        .s_clk_i(s_clk_i), .s_resetn_i(s_resetn_i), .s_valid_i(s_valid_i), .s_op_i(s_op_i),
        .s_csr_addr_i(s_csr_addr_i), .s_val_i(s_val_i), .s_pc_i(s_pc_i),
        .s_trap_i(s_trap_o), .s_mret_i(s_mret_o), .s_cause_i(s_cause),
        .s_exc_tval_i(s_exc_tval),
        .s_int_meip_i(s_int_meip_i), .s_int_mtip_i(s_int_mtip_i), .s_int_msip_i(s_int_msip_i),
        .s_rdata_o(s_rdata_o), .s_addr_legal_o(s_addr_legal),
        .s_mstatus_mie_o(s_mstatus_mie), .s_mie_o(s_mie), .s_mip_o(s_mip),
        .s_mtvec_o(s_mtvec), .s_mepc_o(s_mepc)
    );

endmodule

//--- sim/csr_model.svh
// Reference model of the machine CSR state and trap rules.
// Included inside the testbench module after csr_pkg is imported.
// mip follows the interrupt inputs one cycle late, like the registered CSR.
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

logic            m_mie_bit, m_mpie;
logic [XLEN-1:0] m_mie, m_mip, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;
logic [63:0]     m_mcycle, m_minstret;
logic [XLEN-1:0] exp_rdata, exp_redirect, exp_cause, exp_tval;
logic            exp_trap, exp_mret, exp_legal;

task automatic model_reset();
    m_mie_bit  = 1'b0;
    m_mpie     = 1'b0;
    m_mie      = '0;
    m_mip      = '0;
    m_mtvec    = '0;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mtval    = '0;
    m_mcycle   = '0;
    m_minstret = '0;
endtask

function automatic logic [XLEN-1:0] model_read(input logic [CSR_ADDR_W-1:0] addr,
                                               output logic legal);
    logic [XLEN-1:0] rd;
    legal = 1'b1;
    case (addr)
        CSR_MSTATUS:   rd = {19'b0, MSTATUS_MPP_VAL, 3'b0, m_mpie, 3'b0, m_mie_bit, 3'b0};
        CSR_MIE:       rd = m_mie;
        CSR_MTVEC:     rd = m_mtvec;
        CSR_MSCRATCH:  rd = m_mscratch;
        CSR_MEPC:      rd = m_mepc;
        CSR_MCAUSE:    rd = m_mcause;
        CSR_MTVAL:     rd = m_mtval;
        CSR_MIP:       rd = m_mip;
        CSR_MCYCLE:    rd = m_mcycle[31:0];
        CSR_MCYCLEH:   rd = m_mcycle[63:32];
        CSR_MINSTRET:  rd = m_minstret[31:0];
        CSR_MINSTRETH: rd = m_minstret[63:32];
        default: begin
            rd    = '0;
            legal = 1'b0;
        end
    endcase
    return rd;
endfunction

// expected outputs for the current inputs, state untouched
task automatic model_predict(input logic v, input csr_op_e op,
                             input logic [CSR_ADDR_W-1:0] addr, input logic [XLEN-1:0] val,
                             input ls_size_e size, input logic [XLEN-1:0] pc);
    logic               is_csr, mis, exc, irq;
    logic [CAUSE_W-1:0] code, icode;
    logic [XLEN-1:0]    pend, base;
    exp_rdata = model_read(addr, exp_legal);
    is_csr = (op == OP_CSRRW) || (op == OP_CSRRS) || (op == OP_CSRRC);
    mis = (size == SIZE_HALF && val[0]) || (size == SIZE_WORD && val[1:0] != 2'b00);
    exc = 1'b1;
    exp_tval = '0;
    if (op == OP_ILLEGAL || (is_csr && !exp_legal)) begin
        code = EXC_ILLEGAL;
    end else if (op == OP_ECALL) begin
        code = EXC_ECALL_M;
    end else if (op == OP_EBREAK) begin
        code = EXC_EBREAK;
    end else if ((op == OP_LOAD || op == OP_STORE) && mis) begin
        code = (op == OP_STORE) ? EXC_SADDR_MIS : EXC_LADDR_MIS;
        exp_tval = val;  // faulting address
    end else begin
        exc = 1'b0;
        code = '0;
    end
    pend = m_mie & m_mip;
    irq = m_mie_bit && (pend != '0);
    icode = pend[INT_MEI] ? INT_MEI : pend[INT_MSI] ? INT_MSI : INT_MTI;
    exp_trap = v && (irq || exc);
    exp_mret = v && op == OP_MRET && !exp_trap;
    if (irq) begin
        exp_cause = {1'b1, 26'b0, icode};
        exp_tval = '0;
    end else begin
        exp_cause = {1'b0, 26'b0, code};
    end
    base = {m_mtvec[31:2], 2'b00};
    if (exp_mret) begin
        exp_redirect = m_mepc;
    end else if (exp_trap && irq && m_mtvec[0]) begin
        exp_redirect = base + {25'b0, icode, 2'b00};  // vectored entry
    end else if (exp_trap) begin
        exp_redirect = base;
    end else begin
        exp_redirect = pc + 32'd4;
    end
endtask

// state as it stands after the next rising edge
task automatic model_advance(input logic v, input csr_op_e op,
                             input logic [CSR_ADDR_W-1:0] addr, input logic [XLEN-1:0] val,
                             input logic [XLEN-1:0] pc, input logic [2:0] irq);
    logic [XLEN-1:0] w;
    logic [63:0]     cyc, ins;
    logic            we;
    w = (op == OP_CSRRW) ? val : (op == OP_CSRRS) ? (exp_rdata | val) : (exp_rdata & ~val);
    we = v && !exp_trap && (op == OP_CSRRW || op == OP_CSRRS || op == OP_CSRRC);
    cyc = m_mcycle + 64'd1;
    ins = m_minstret + {63'b0, v && !exp_trap};
    if (exp_trap) begin
        m_mepc    = pc;
        m_mcause  = exp_cause;
        m_mtval   = exp_tval;
        m_mpie    = m_mie_bit;
        m_mie_bit = 1'b0;
    end else if (exp_mret) begin
        m_mie_bit = m_mpie;
        m_mpie    = 1'b1;
    end else if (we) begin
        case (addr)
            CSR_MSTATUS: begin
                m_mie_bit = w[MSTATUS_MIE];
                m_mpie    = w[MSTATUS_MPIE];
            end
            CSR_MIE:       m_mie      = w & 32'h0000_0888;
            CSR_MTVEC:     m_mtvec    = w & ~32'h2;
            CSR_MSCRATCH:  m_mscratch = w;
            CSR_MEPC:      m_mepc     = w;
            CSR_MCAUSE:    m_mcause   = w;
            CSR_MTVAL:     m_mtval    = w;
            CSR_MCYCLE:    cyc = {m_mcycle[63:32], w};
            CSR_MCYCLEH:   cyc = {w, m_mcycle[31:0]};
            CSR_MINSTRET:  ins = {m_minstret[63:32], w};
            CSR_MINSTRETH: ins = {w, m_minstret[31:0]};
            default: ;  // mip ignores writes
        endcase
    end
    m_mcycle   = cyc;
    m_minstret = ins;
    m_mip      = {20'b0, irq[2], 3'b0, irq[1], 3'b0, irq[0], 3'b0};  // meip, mtip, msip
endtask

`endif

//--- sim/csr_tb.sv
// Testbench for the machine-mode CSR and trap unit.
// A short directed prologue, then xorshift stimulus from a fixed seed.
// Outputs are checked mid-cycle against the included reference model.

module csr_tb;
    import csr_pkg::*;

    localparam int RESET_CYC   = 16;
    localparam int N_DIRECTED  = 40;   // upper bound on directed steps
    localparam int N_STEPS     = 400;
    localparam int TIMEOUT_CYC = RESET_CYC + N_DIRECTED + N_STEPS + 100;

    logic                  s_clk = 1'b0;
    logic                  s_resetn, s_valid;
    csr_op_e               s_op;
    logic [CSR_ADDR_W-1:0] s_csr_addr;
    logic [XLEN-1:0]       s_val, s_pc;
    ls_size_e              s_size;
    logic                  s_meip, s_mtip, s_msip;
    logic [XLEN-1:0]       s_rdata, s_redirect_pc;
    logic                  s_trap, s_mret;
    logic [31:0]           rng;
    int                    err_count, check_count, cycle_cnt;

    `include "csr_model.svh"

    csr_unit_top csr_unit_top_inst (
        .s_clk_i(s_clk), .s_resetn_i(s_resetn), .s_valid_i(s_valid), .s_op_i(s_op),
        .s_csr_addr_i(s_csr_addr), .s_val_i(s_val), .s_size_i(s_size), .s_pc_i(s_pc),
        .s_int_meip_i(s_meip), .s_int_mtip_i(s_mtip), .s_int_msip_i(s_msip),
        .s_rdata_o(s_rdata), .s_trap_o(s_trap), .s_mret_o(s_mret),
        .s_redirect_pc_o(s_redirect_pc)
    );

    always #10 s_clk = ~s_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [CSR_ADDR_W-1:0] legal_addr(input logic [3:0] idx);
        case (idx)
            4'd0:    return CSR_MSTATUS;
            4'd1:    return CSR_MIE;
            4'd2:    return CSR_MTVEC;
            4'd3:    return CSR_MSCRATCH;
            4'd4:    return CSR_MEPC;
            4'd5:    return CSR_MCAUSE;
            4'd6:    return CSR_MTVAL;
            4'd7:    return CSR_MIP;
            4'd8:    return CSR_MCYCLE;
            4'd9:    return CSR_MCYCLEH;
            4'd10:   return CSR_MINSTRET;
            4'd11:   return CSR_MINSTRETH;
            default: return CSR_MIE;  // extra weight on mie
        endcase
    endfunction

    task automatic check_val(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // entered 2 units after a rising edge, returns at the same point one cycle on
    task automatic do_step(input logic v, input csr_op_e op, input logic [CSR_ADDR_W-1:0] addr,
                           input logic [XLEN-1:0] val, input ls_size_e size,
                           input logic [XLEN-1:0] pc, input logic [2:0] irq);
        s_valid    = v;
        s_op       = op;
        s_csr_addr = addr;
        s_val      = val;
        s_size     = size;
        s_pc       = pc;
        {s_meip, s_mtip, s_msip} = irq;
        #8;  // mid-cycle, outputs settled
        model_predict(v, op, addr, val, size, pc);
        check_val("s_rdata_o", s_rdata, exp_rdata);
        check_val("s_trap_o", 32'(s_trap), 32'(exp_trap));
        check_val("s_mret_o", 32'(s_mret), 32'(exp_mret));
        check_val("s_redirect_pc_o", s_redirect_pc, exp_redirect);
        model_advance(v, op, addr, val, pc, irq);
        @(posedge s_clk);
        #2;
    endtask

    task automatic random_step();
        logic [31:0]           r, a, b;
        csr_op_e               op;
        ls_size_e              size;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       val;
        rng = xorshift32(rng);
        r = rng;
        rng = xorshift32(rng);
        a = rng;
        rng = xorshift32(rng);
        b = rng;
        case (r[3:0])
            4'd0, 4'd1, 4'd2: op = OP_CSRRW;
            4'd3, 4'd4, 4'd5: op = OP_CSRRS;
            4'd6, 4'd7:       op = OP_CSRRC;
            4'd8:             op = OP_ECALL;
            4'd9:             op = OP_EBREAK;
            4'd10, 4'd11:     op = OP_MRET;
            4'd12:            op = OP_LOAD;
            4'd13:            op = OP_STORE;
            4'd14:            op = OP_ILLEGAL;
            default:          op = OP_NONE;
        endcase
        case (r[5:4])
            2'd0:    size = SIZE_BYTE;
            2'd1:    size = SIZE_HALF;
            default: size = SIZE_WORD;
        endcase
        addr = (r[8:6] == 3'd0) ? a[CSR_ADDR_W-1:0] : legal_addr(r[12:9]);  // mostly legal
        val = (r[14:13] == 2'd0) ? (32'hFFFF_FFF0 | {28'b0, b[3:0]}) : b;     // near carry
        do_step(r[15] | r[16], op, addr, val, size, {a[31:2], 2'b00},
                {r[20:18] == 3'd0, r[23:21] == 3'd0, r[26:24] == 3'd0});
    endtask

    initial begin
        rng         = 32'd22;
        err_count   = 0;
        check_count = 0;
        s_resetn    = 1'b0;
        s_valid     = 1'b0;
        s_op        = OP_NONE;
        s_csr_addr  = '0;
        s_val       = '0;
        s_size      = SIZE_WORD;
        s_pc        = '0;
        s_meip      = 1'b0;
        s_mtip      = 1'b0;
        s_msip      = 1'b0;
        repeat (RESET_CYC) @(posedge s_clk);
        #2;
        s_resetn = 1'b1;
        model_reset();
        for (int i = 0; i < 12; i++) begin
            do_step(1'b1, OP_NONE, legal_addr(4'(i)), '0, SIZE_WORD, '0, 3'b000);
        end
        do_step(1'b1, OP_NONE, CSR_MCYCLE, '0, SIZE_WORD, '0, 3'b000);
        // vectored mtvec, all sources enabled, then meip and msip together
        do_step(1'b1, OP_CSRRW, CSR_MTVEC, 32'h0000_0101, SIZE_WORD, 32'h40, 3'b000);
        do_step(1'b1, OP_CSRRW, CSR_MIE, 32'hFFFF_FFFF, SIZE_WORD, 32'h44, 3'b000);
        do_step(1'b1, OP_CSRRS, CSR_MSTATUS, 32'h8, SIZE_WORD, 32'h48, 3'b000);
        do_step(1'b0, OP_NONE, CSR_MIP, '0, SIZE_WORD, '0, 3'b101);
        do_step(1'b1, OP_CSRRW, CSR_MSCRATCH, 32'h1234, SIZE_WORD, 32'h80, 3'b101);
        do_step(1'b1, OP_MRET, CSR_MSTATUS, '0, SIZE_WORD, 32'h12C, 3'b000);
        do_step(1'b1, OP_NONE, CSR_MSTATUS, '0, SIZE_WORD, 32'h84, 3'b000);
        // synchronous exceptions
        do_step(1'b1, OP_LOAD, CSR_MSTATUS, 32'h1002, SIZE_WORD, 32'h90, 3'b000);
        do_step(1'b1, OP_NONE, CSR_MTVAL, '0, SIZE_WORD, 32'h100, 3'b000);
        do_step(1'b1, OP_STORE, CSR_MEPC, 32'h2001, SIZE_HALF, 32'h94, 3'b000);
        do_step(1'b1, OP_ECALL, CSR_MCAUSE, '0, SIZE_WORD, 32'h98, 3'b000);
        do_step(1'b1, OP_CSRRW, 12'h7C0, 32'h5, SIZE_WORD, 32'h9C, 3'b000);
        do_step(1'b1, OP_NONE, CSR_MCAUSE, '0, SIZE_WORD, 32'hA0, 3'b000);
        // counters across the low-word carry
        do_step(1'b1, OP_CSRRW, CSR_MCYCLE, 32'hFFFF_FFFD, SIZE_WORD, 32'hA4, 3'b000);
        do_step(1'b1, OP_CSRRW, CSR_MINSTRET, 32'hFFFF_FFFE, SIZE_WORD, 32'hA8, 3'b000);
        repeat (3) do_step(1'b1, OP_NONE, CSR_MCYCLEH, '0, SIZE_WORD, 32'hAC, 3'b000);
        do_step(1'b1, OP_NONE, CSR_MINSTRETH, '0, SIZE_WORD, 32'hB0, 3'b000);
        repeat (N_STEPS) random_step();
        $display("checks: %0d  errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYC) begin
            @(posedge s_clk);
            cycle_cnt++;
        end
        $display("timeout: run did not end within %0d cycles", TIMEOUT_CYC);
        $display("Test failed");
        $finish;
    end

endmodule

//--- files.f
+incdir+sim
common/csr_pkg.sv
trap/exc_detect.sv
trap/trap_ctrl.sv
csr/csr_file.sv
design/csr_unit_top.sv
sim/csr_tb.sv

//--- run.sh
#!/bin/sh
# Builds the CSR unit testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module csr_tb -f files.f -o csr_sim
./obj_dir/csr_sim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
